//--- include/frontDecode_cfg.svh
// decode front end configuration
// parcel buffer depth and the trap cause codes raised by decode
`ifndef FRONTDECODE_CFG_SVH
`define FRONTDECODE_CFG_SVH

// number of parcel slots in the fetch buffer, must be a power of two
`define FD_BUF_DEPTH 8

// exception cause codes of the privileged spec
`define FD_EXC_ILLEGAL_INSN 2
`define FD_EXC_INSN_PAGE_FAULT 12

`endif

//--- verilog/frontDecodePkg.sv
// shared types of the decode front end
// parcel, micro-op, trap and decoded instruction records
`include "frontDecode_cfg.svh"

package frontDecodePkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [15:0] parcel_t;
    typedef logic [31:0] insn_t;            // compressed forms sit zero-extended in here
    typedef logic [4:0] regAddr_t;
    typedef logic [31:0] imm_t;
    typedef logic [11:0] csrAddr_t;
    typedef logic [4:0] causeCode_t;
    typedef logic [31:0] trapValue_t;       // pc or instruction word, depending on the trap

    typedef logic [$clog2(`FD_BUF_DEPTH)-1:0] bufPtr_t;
    typedef logic [$clog2(`FD_BUF_DEPTH):0] bufCount_t;   // one extra bit to hold a full count

    typedef enum logic [3:0] {
        OP_NONE,
        OP_ALU_REG,
        OP_ALU_IMM,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_JAL,
        OP_JALR,
        OP_LUI,
        OP_AUIPC,
        OP_SYSTEM,
        OP_UNKNOWN
    } opClass_e;

    typedef enum causeCode_t {
        EXC_ILLEGAL_INSN = `FD_EXC_ILLEGAL_INSN,
        EXC_INSN_PAGE_FAULT = `FD_EXC_INSN_PAGE_FAULT
    } excCode_e;

    typedef struct packed {
        vaddr_t pc;
        parcel_t data;
        logic fault;                        // fetch page fault on this parcel
        logic interruptValid;
        causeCode_t interruptCode;
    } fetchParcel_s;

    typedef struct packed {
        opClass_e opClass;
        regAddr_t rd;
        regAddr_t rs1;
        regAddr_t rs2;
        imm_t imm;                          // already sign-extended and scaled
    } microOp_s;

    typedef struct packed {
        logic valid;
        logic isInterrupt;
        causeCode_t code;
        trapValue_t value;
    } trapInfo_s;

    typedef struct packed {
        logic valid;
        vaddr_t pc;
        insn_t insn;
        logic isCompressed;
        csrAddr_t csrAddr;
        microOp_s op;
        trapInfo_s trap;
    } decodedInsn_s;

endpackage

//--- verilog/parcelBuffer.sv
// circular buffer of fetched instruction parcels
// one push per cycle, pops one or two of the oldest parcels
`include "frontDecode_cfg.svh"

module parcelBuffer (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic pushValid,
    input  frontDecodePkg::fetchParcel_s pushParcel,
    output logic full,
    input  logic popLow,
    input  logic popHigh,
    output frontDecodePkg::fetchParcel_s readLow,
    output frontDecodePkg::fetchParcel_s readHigh,
    output frontDecodePkg::bufCount_t readableCount
);
    import frontDecodePkg::*;

    localparam int DEPTH = `FD_BUF_DEPTH;

    fetchParcel_s slots [DEPTH];
    bufPtr_t readPtr;
    bufPtr_t writePtr;
    bufCount_t count;

    logic pushAccept;
    bufCount_t popCount;
    bufPtr_t nextReadPtr;

    always_comb begin
        full = (count == bufCount_t'(DEPTH));
        pushAccept = pushValid && !full;                // fetch holds the parcel while full
        popCount = bufCount_t'(popLow) + bufCount_t'(popLow && popHigh);
        nextReadPtr = readPtr + bufPtr_t'(1);           // wraps since depth is a power of two
    end

    always_comb begin
        readLow = slots[readPtr];
        readHigh = slots[nextReadPtr];                  // only meaningful when count is two or more
        readableCount = count;
    end

    // parcel storage
    always_ff @(posedge clk) begin
        if (pushAccept) begin
            slots[writePtr] <= pushParcel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            readPtr <= '0;
            writePtr <= '0;
            count <= '0;
        end
        else begin
            if (pushAccept) begin
                writePtr <= writePtr + bufPtr_t'(1);
            end
            readPtr <= readPtr + bufPtr_t'(popCount);
            count <= count + bufCount_t'(pushAccept) - popCount;   // push and pop may overlap
        end
    end

endmodule

//--- verilog/rv32Decoder.sv
// RV32I base instruction decoder
// maps a 32-bit instruction to its op class, register fields and immediate
module rv32Decoder (
    input  frontDecodePkg::insn_t insn,
    output frontDecodePkg::microOp_s op
);
    import frontDecodePkg::*;

    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    regAddr_t rd;
    regAddr_t rs1;
    regAddr_t rs2;
    imm_t immI;
    imm_t immS;
    imm_t immB;
    imm_t immU;
    imm_t immJ;

    always_comb begin
        opcode = insn[6:0];
        funct3 = insn[14:12];
        rd = insn[11:7];
        rs1 = insn[19:15];
        rs2 = insn[24:20];
        immI = {{20{insn[31]}}, insn[31:20]};
        immS = {{20{insn[31]}}, insn[31:25], insn[11:7]};
        immB = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
        immU = {insn[31:12], 12'h000};
        immJ = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    end

    always_comb begin
        op = '0;
        op.opClass = OP_UNKNOWN;                        // stays so for unlisted encodings
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                op.opClass = (opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
                op.rd = rd;
                op.imm = immU;
            end
            OPC_JAL: begin
                op = '{opClass: OP_JAL, rd: rd, rs1: '0, rs2: '0, imm: immJ};
            end
            OPC_JALR: begin
                op = '{opClass: OP_JALR, rd: rd, rs1: rs1, rs2: '0, imm: immI};
            end
            OPC_BRANCH: begin
                if (!(funct3 inside {3'b010, 3'b011})) begin
                    op = '{opClass: OP_BRANCH, rd: '0, rs1: rs1, rs2: rs2, imm: immB};
                end
            end
            OPC_LOAD: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    op = '{opClass: OP_LOAD, rd: rd, rs1: rs1, rs2: '0, imm: immI};
                end
            end
            OPC_STORE: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
                    op = '{opClass: OP_STORE, rd: '0, rs1: rs1, rs2: rs2, imm: immS};
                end
            end
            OPC_OP_IMM: begin
                op = '{opClass: OP_ALU_IMM, rd: rd, rs1: rs1, rs2: '0, imm: immI};
            end
            OPC_OP: begin
                op = '{opClass: OP_ALU_REG, rd: rd, rs1: rs1, rs2: rs2, imm: '0};
            end
            OPC_SYSTEM: begin
                // csr number rides in the I immediate, csrAddr is taken by the stage
                op = '{opClass: OP_SYSTEM, rd: rd, rs1: rs1, rs2: '0, imm: immI};
            end
            default: begin
                op.opClass = OP_UNKNOWN;
            end
        endcase
    end

endmodule

//--- verilog/rvcDecoder.sv
// compressed instruction decoder
// expands C.ADDI, C.LI, C.MV, C.ADD, C.J, C.LW and C.SW into base micro-ops
module rvcDecoder (
    input  frontDecodePkg::parcel_t parcel,
    output frontDecodePkg::microOp_s op
);
    import frontDecodePkg::*;

    logic [1:0] quadrant;
    logic [2:0] funct3;
    regAddr_t rdFull;
    regAddr_t rs2Full;
    regAddr_t rdPrime;
    regAddr_t rs1Prime;
    imm_t immCi;
    imm_t immCj;
    imm_t immWord;

    always_comb begin
        quadrant = parcel[1:0];
        funct3 = parcel[15:13];
        rdFull = parcel[11:7];
        rs2Full = parcel[6:2];
        rdPrime = {2'b01, parcel[4:2]};                 // x8..x15
        rs1Prime = {2'b01, parcel[9:7]};
        immCi = {{27{parcel[12]}}, parcel[6:2]};
        immCj = {{21{parcel[12]}}, parcel[8], parcel[10:9], parcel[6], parcel[7],
                 parcel[2], parcel[11], parcel[5:3], 1'b0};
        immWord = {25'h0, parcel[5], parcel[12:10], parcel[6], 2'b00};   // word-scaled offset
    end

    always_comb begin
        op = '0;
        op.opClass = OP_UNKNOWN;
        case ({quadrant, funct3})
            5'b01_000: begin                            // C.ADDI
                op = '{opClass: OP_ALU_IMM, rd: rdFull, rs1: rdFull, rs2: '0, imm: immCi};
            end
            5'b01_010: begin                            // C.LI
                op = '{opClass: OP_ALU_IMM, rd: rdFull, rs1: '0, rs2: '0, imm: immCi};
            end
            5'b01_101: begin                            // C.J
                op = '{opClass: OP_JAL, rd: '0, rs1: '0, rs2: '0, imm: immCj};
            end
            5'b00_010: begin                            // C.LW
                op = '{opClass: OP_LOAD, rd: rdPrime, rs1: rs1Prime, rs2: '0, imm: immWord};
            end
            5'b00_110: begin                            // C.SW
                op = '{opClass: OP_STORE, rd: '0, rs1: rs1Prime, rs2: rdPrime, imm: immWord};
            end
            5'b10_100: begin
                // rs2 of zero here encodes jumps and ebreak, which are not supported
                if (rs2Full != '0) begin
                    op.opClass = OP_ALU_REG;
                    op.rd = rdFull;
                    op.rs1 = parcel[12] ? rdFull : '0;  // C.ADD adds to rd, C.MV adds to x0
                    op.rs2 = rs2Full;
                end
            end
            default: begin
                op.opClass = OP_UNKNOWN;
            end
        endcase
    end

endmodule

//--- verilog/decodeStage.sv
// decode stage control and pipeline register
// picks the instruction length, ranks traps, pops parcels and registers the result
module decodeStage (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic flush,
    input  frontDecodePkg::fetchParcel_s readLow,
    input  frontDecodePkg::fetchParcel_s readHigh,
    input  frontDecodePkg::bufCount_t readableCount,
    input  frontDecodePkg::microOp_s fullOp,
    input  frontDecodePkg::microOp_s compOp,
    output logic popLow,
    output logic popHigh,
    output frontDecodePkg::decodedInsn_s decoded
);
    import frontDecodePkg::*;

    logic isCompressed;
    logic canDecode;
    insn_t insnWord;
    microOp_s selOp;
    trapInfo_s trap;
    decodedInsn_s nextDecoded;

    always_comb begin
        isCompressed = (readLow.data[1:0] != 2'b11);
        canDecode = (readableCount >= bufCount_t'(2))
                 || (readableCount == bufCount_t'(1) && isCompressed);
        insnWord = isCompressed ? {16'h0000, readLow.data} : {readHigh.data, readLow.data};
        selOp = isCompressed ? compOp : fullOp;
    end

    // priority is low interrupt, high interrupt, page fault, then illegal instruction
    always_comb begin
        trap = '0;
        if (canDecode) begin
            if (readLow.interruptValid) begin
                trap = '{valid: 1'b1, isInterrupt: 1'b1, code: readLow.interruptCode,
                         value: readLow.pc};
            end
            else if (!isCompressed && readHigh.interruptValid) begin
                trap = '{valid: 1'b1, isInterrupt: 1'b1, code: readHigh.interruptCode,
                         value: readLow.pc};            // reported at the instruction's pc
            end
            else if (readLow.fault || (!isCompressed && readHigh.fault)) begin
                trap = '{valid: 1'b1, isInterrupt: 1'b0, code: EXC_INSN_PAGE_FAULT,
                         value: readLow.pc};
            end
            else if (selOp.opClass == OP_UNKNOWN) begin
                trap = '{valid: 1'b1, isInterrupt: 1'b0, code: EXC_ILLEGAL_INSN,
                         value: insnWord};
            end
        end
    end

    always_comb begin
        nextDecoded.valid = 1'b1;
        nextDecoded.pc = readLow.pc;
        nextDecoded.insn = insnWord;
        nextDecoded.isCompressed = isCompressed;
        nextDecoded.csrAddr = insnWord[31:20];
        nextDecoded.op = selOp;
        nextDecoded.trap = trap;
    end

    always_comb begin
        popLow = canDecode && !stall;
        popHigh = canDecode && !stall && !isCompressed;   // second half of a 32-bit word
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            decoded <= '0;                              // flush wins over stall
        end
        else if (!stall) begin
            decoded <= canDecode ? nextDecoded : '0;
        end
    end

endmodule

//--- verilog/frontDecode.sv
// decode front end top level
// parcel buffer feeding the base and compressed decoders and the decode stage
module frontDecode (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic stall,
    input  logic pushValid,
    input  frontDecodePkg::fetchParcel_s pushParcel,
    output logic full,
    output frontDecodePkg::decodedInsn_s decoded
);
    import frontDecodePkg::*;

    fetchParcel_s readLow;
    fetchParcel_s readHigh;
    bufCount_t readableCount;
    logic popLow;
    logic popHigh;
    microOp_s fullOp;
    microOp_s compOp;

    parcelBuffer parcelBuffer_inst (
        .clk(clk), .rst(rst), .flush(flush),
        .pushValid(pushValid), .pushParcel(pushParcel), .full(full),
        .popLow(popLow), .popHigh(popHigh),
        .readLow(readLow), .readHigh(readHigh), .readableCount(readableCount)
    );

    rv32Decoder rv32Decoder_inst (
        .insn({readHigh.data, readLow.data}),           // high parcel holds the upper half
        .op(fullOp)
    );

    rvcDecoder rvcDecoder_inst (.parcel(readLow.data), .op(compOp));

    decodeStage decodeStage_inst (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush),
        .readLow(readLow), .readHigh(readHigh), .readableCount(readableCount),
        .fullOp(fullOp), .compOp(compOp),
        .popLow(popLow), .popHigh(popHigh), .decoded(decoded)
    );

endmodule

//--- bench/frontDecode_assert.sv
// decode front end checker
// concurrent assertions on reset, stall, flush and buffer occupancy, bound into frontDecode
`include "frontDecode_cfg.svh"

module frontDecode_assert (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic stall,
    input logic pushValid,
    input logic full,
    input logic popLow,
    input logic popHigh,
    input frontDecodePkg::decodedInsn_s decoded
);
    timeunit 1ns;
    timeprecision 1ps;

    int occupancy;                                      // parcels held in the buffer

    always @(posedge clk) begin
        if (rst || flush) begin
            occupancy <= 0;
        end
        else begin
            occupancy <= occupancy + int'(pushValid && !full) - int'(popLow) - int'(popHigh);
        end
    end

    resetClears: assert property (@(posedge clk) rst |=> !decoded.valid)
        else $error("decoded is valid in the cycle after reset");

    stallHolds: assert property (@(posedge clk) disable iff (rst)
        (stall && !flush) |=> $stable(decoded))
        else $error("decoded changed across a stalled edge");

    flushClears: assert property (@(posedge clk) flush |=> !decoded.valid)
        else $error("decoded is valid after a flush");

    // full has to rise exactly when the buffer holds its depth in parcels
    fullBounds: assert property (@(posedge clk) disable iff (rst)
        (occupancy <= `FD_BUF_DEPTH) && (full == (occupancy == `FD_BUF_DEPTH)))
        else $error("buffer accepted more parcels than its depth");

endmodule

bind frontDecode frontDecode_assert frontDecode_assert_inst (
    .clk(clk), .rst(rst), .flush(flush), .stall(stall), .pushValid(pushValid),
    .full(full), .popLow(popLow), .popHigh(popHigh), .decoded(decoded)
);

//--- bench/frontDecodeTb.sv
// decode front end testbench
// directed tests of base, compressed, trap, stall, back-pressure and flush behavior
`include "frontDecode_cfg.svh"

module frontDecodeTb;
    timeunit 1ns;
    timeprecision 1ps;
    import frontDecodePkg::*;

    localparam int CYCLE_LIMIT = 2000;                  // all tests together need a few hundred

    logic clk;
    logic rst;
    logic flush;
    logic stall;
    logic pushValid;
    fetchParcel_s pushParcel;
    logic full;
    decodedInsn_s decoded;

    decodedInsn_s expQ[$];                              // instructions still to come out, oldest first
    string testName;
    vaddr_t pc;
    logic [15:0] lfsr;
    logic stallAtEdge;
    int cycles;

    frontDecode frontDecode_inst (
        .clk(clk), .rst(rst), .flush(flush), .stall(stall), .pushValid(pushValid),
        .pushParcel(pushParcel), .full(full), .decoded(decoded)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        stallAtEdge <= stall;
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            abortRun($sformatf("timeout, tests still running after %0d cycles", CYCLE_LIMIT));
        end
    end

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);   // Galois taps 16,14,13,11
        end
        return r;
    endfunction

    task automatic checkMicroOp(input microOp_s exp, input microOp_s act);
        if (act !== exp) begin
            abortRun($sformatf("mismatch in %s micro-op: expected %h actual %h",
                               testName, exp, act));
        end
    endtask

    task automatic checkTrap(input trapInfo_s exp, input trapInfo_s act);
        if (act !== exp) begin
            abortRun($sformatf("mismatch in %s trap: expected %h actual %h", testName, exp, act));
        end
    endtask

    task automatic checkFull(input logic exp, input logic act);
        if (act !== exp) begin
            abortRun($sformatf("mismatch in %s full: expected %b actual %b", testName, exp, act));
        end
    endtask

    task automatic checkDecoded(input decodedInsn_s exp, input decodedInsn_s act);
        checkMicroOp(exp.op, act.op);
        checkTrap(exp.trap, act.trap);
        if (act !== exp) begin
            abortRun($sformatf("mismatch in %s decoded: expected %h actual %h",
                               testName, exp, act));
        end
    endtask

    // a new result is loaded on every edge without stall
    always @(negedge clk) begin
        if (!rst && !stallAtEdge && decoded.valid) begin
            if (expQ.size() == 0) begin
                abortRun($sformatf("%s decoded an instruction that was never pushed", testName));
            end
            else begin
                checkDecoded(expQ.pop_front(), decoded);
            end
        end
    end

    // kinds 0..6 are ADDI LW SW BEQ JAL LUI CSRRW, 7..10 are C.ADDI C.MV C.LW C.J
    task automatic makeInsn(input int kind, output insn_t w, output microOp_s op);
        regAddr_t rd;
        regAddr_t rs1;
        regAddr_t rs2;
        logic [11:0] i12;
        logic [19:0] i20;
        imm_t immI;
        rd = regAddr_t'(randBits(5));
        rs1 = regAddr_t'(randBits(5));
        rs2 = regAddr_t'(randBits(5));
        i12 = 12'(randBits(12));
        i20 = 20'(randBits(20));
        if (rs2 == '0) begin
            rs2 = 5'd1;                                 // C.MV needs a nonzero source
        end
        immI = {{20{i12[11]}}, i12};
        case (kind)
            0: w = {i12, rs1, 3'b000, rd, 7'b0010011};
            1: w = {i12, rs1, 3'b010, rd, 7'b0000011};
            2: w = {i12[11:5], rs2, rs1, 3'b010, i12[4:0], 7'b0100011};
            3: w = {i12[11], i12[9:4], rs2, rs1, 3'b000, i12[3:0], i12[10], 7'b1100011};
            4: w = {i20[19], i20[9:0], i20[10], i20[18:11], rd, 7'b1101111};
            5: w = {i20, rd, 7'b0110111};
            6: w = {i12, rs1, 3'b001, rd, 7'b1110011};
            7: w = {16'h0, 3'b000, i12[5], rd, i12[4:0], 2'b01};
            8: w = {16'h0, 4'b1000, rd, rs2, 2'b10};
            9: w = {16'h0, 3'b010, i12[3:1], rs1[2:0], i12[0], i12[4], rd[2:0], 2'b00};
            10: w = {16'h0, 3'b101, i12[10], i12[3], i12[8:7], i12[9], i12[5], i12[6],
                     i12[2:0], i12[4], 2'b01};
            default: w = {16'h0, 16'h0506};             // C.SLLI x10, outside the subset
        endcase
        case (kind)
            0: op = '{OP_ALU_IMM, rd, rs1, 5'd0, immI};
            1: op = '{OP_LOAD, rd, rs1, 5'd0, immI};
            2: op = '{OP_STORE, 5'd0, rs1, rs2, immI};
            3: op = '{OP_BRANCH, 5'd0, rs1, rs2, {{19{i12[11]}}, i12, 1'b0}};
            4: op = '{OP_JAL, rd, 5'd0, 5'd0, {{11{i20[19]}}, i20, 1'b0}};
            5: op = '{OP_LUI, rd, 5'd0, 5'd0, {i20, 12'h000}};
            6: op = '{OP_SYSTEM, rd, rs1, 5'd0, immI};
            7: op = '{OP_ALU_IMM, rd, rd, 5'd0, {{26{i12[5]}}, i12[5:0]}};
            8: op = '{OP_ALU_REG, rd, 5'd0, rs2, 32'd0};
            9: op = '{OP_LOAD, {2'b01, rd[2:0]}, {2'b01, rs1[2:0]}, 5'd0, {25'd0, i12[4:0], 2'b00}};
            10: op = '{OP_JAL, 5'd0, 5'd0, 5'd0, {{20{i12[10]}}, i12[10:0], 1'b0}};
            default: op = '{OP_UNKNOWN, 5'd0, 5'd0, 5'd0, 32'd0};
        endcase
    endtask

    task automatic sendParcel(input fetchParcel_s p);
        @(negedge clk);
        while (full) begin
            pushValid = 1'b0;
            @(negedge clk);
        end
        pushValid = 1'b1;
        pushParcel = p;
    endtask

    task automatic endPush();
        @(negedge clk);
        pushValid = 1'b0;
    endtask

    task automatic sendInsn(input insn_t w, input microOp_s op, input logic faultLow,
                            input logic faultHigh, input logic irq, input causeCode_t irqCode);
        logic comp;
        decodedInsn_s e;
        comp = (w[1:0] != 2'b11);
        e = '0;
        e.valid = 1'b1;
        e.pc = pc;
        e.insn = comp ? {16'h0, w[15:0]} : w;
        e.isCompressed = comp;
        e.csrAddr = e.insn[31:20];
        e.op = op;
        if (irq) begin
            e.trap = '{1'b1, 1'b1, irqCode, pc};
        end
        else if (faultLow || (!comp && faultHigh)) begin
            e.trap = '{1'b1, 1'b0, causeCode_t'(`FD_EXC_INSN_PAGE_FAULT), pc};
        end
        else if (op.opClass == OP_UNKNOWN) begin
            e.trap = '{1'b1, 1'b0, causeCode_t'(`FD_EXC_ILLEGAL_INSN), e.insn};
        end
        expQ.push_back(e);
        sendParcel('{pc, w[15:0], faultLow, irq, irqCode});
        if (!comp) begin
            sendParcel('{pc + 32'd2, w[31:16], faultHigh, 1'b0, 5'd0});
        end
        pc = pc + (comp ? 32'd2 : 32'd4);
    endtask

    task automatic sendKind(input int kind);
        insn_t w;
        microOp_s op;
        makeInsn(kind, w, op);
        sendInsn(w, op, 1'b0, 1'b0, 1'b0, 5'd0);
    endtask

    task automatic drain();
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic testBase();
        testName = "base decode";
        for (int k = 0; k < 7; k++) begin
            sendKind(k);
        end
        endPush();
        drain();
    endtask

    task automatic testMixed();
        int kinds[10] = '{7, 0, 8, 3, 9, 2, 10, 4, 8, 6};
        testName = "mixed stream";
        foreach (kinds[k]) begin
            sendKind(kinds[k]);
        end
        endPush();
        drain();
    endtask

    task automatic testTraps();
        insn_t w;
        microOp_s op;
        testName = "traps";
        makeInsn(11, w, op);
        sendInsn(w, op, 1'b0, 1'b0, 1'b0, 5'd0);
        makeInsn(0, w, op);
        sendInsn(w, op, 1'b0, 1'b1, 1'b0, 5'd0);       // fault on the upper half only
        makeInsn(1, w, op);
        sendInsn(w, op, 1'b1, 1'b0, 1'b1, 5'd11);      // interrupt outranks the fault
        endPush();
        drain();
    endtask

    task automatic testStall();
        decodedInsn_s held;
        testName = "stall";
        sendKind(0);
        held = expQ[$];                                 // the ADDI sits in decoded once stall rises
        sendKind(7);
        sendKind(8);
        stall = 1'b1;
        sendKind(1);
        sendKind(9);
        endPush();
        repeat (4) begin
            @(negedge clk);
            checkDecoded(held, decoded);
        end
        stall = 1'b0;
        drain();
    endtask

    task automatic testBackPressure();
        testName = "back-pressure";
        @(negedge clk);
        stall = 1'b1;
        for (int k = 0; k < `FD_BUF_DEPTH; k++) begin
            sendKind(7 + k % 4);                        // one parcel each
        end
        @(negedge clk);
        checkFull(1'b1, full);
        pushParcel = '{pc, 16'h4501, 1'b0, 1'b0, 5'd0};   // C.LI that must be dropped
        repeat (3) @(negedge clk);
        checkFull(1'b1, full);
        pushValid = 1'b0;
        stall = 1'b0;
        drain();
        repeat (4) @(negedge clk);
    endtask

    task automatic testFlush();
        testName = "flush";
        sendKind(0);
        sendKind(8);
        endPush();
        stall = 1'b1;                                   // keeps the ADDI in decoded
        sendKind(3);
        endPush();
        expQ.delete();                                  // these never reach decoded
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        stall = 1'b0;
        checkDecoded('0, decoded);
        repeat (3) @(negedge clk);
        sendKind(9);
        endPush();
        drain();
    endtask

    initial begin
        lfsr = 16'd23335;
        pc = 32'h0000_1000;
        rst = 1'b1;
        flush = 1'b0;
        stall = 1'b0;
        pushValid = 1'b0;
        pushParcel = '0;
        testName = "reset";
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkFull(1'b0, full);
        checkDecoded('0, decoded);
        testBase();
        testMixed();
        testTraps();
        testStall();
        testBackPressure();
        testFlush();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- frontDecode.f
+incdir+include
verilog/frontDecodePkg.sv
verilog/parcelBuffer.sv
verilog/rv32Decoder.sv
verilog/rvcDecoder.sv
verilog/decodeStage.sv
verilog/frontDecode.sv
bench/frontDecode_assert.sv
bench/frontDecodeTb.sv

//--- Makefile
# Verilator build and run of the decode front end testbench
VERILATOR ?= verilator
TOP ?= frontDecodeTb
FILELIST ?= frontDecode.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
